// File: all.f
+incdir+bench
rtl/mipsPkg.sv
rtl/instrClassifier.sv
rtl/dataMemory.sv
rtl/memStage.sv
rtl/regFile.sv
rtl/memWbTop.sv
bench/memWbProperties.sv
bench/memWbTb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and decide on the log contents
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module memWbTb -f all.f -o memWbSim
./obj_dir/memWbSim > sim.log 2>&1 || true
cat sim.log
if grep -q "^TB PASSED$" sim.log; then
    exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

// File: bench/memWbTasks.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bundle builders, issue and compare tasks, directed tests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic stopOnError();
    $display("TB FAILED");
    $fatal(1, "stopped at first error");
endtask

task automatic checkWord(input string name, input mipsPkg::word got,
                         input mipsPkg::word exp);
    if (got !== exp) begin
        errorCount++;
        $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
        stopOnError();
    end
endtask

task automatic checkAddr(input string name, input mipsPkg::regAddr got,
                         input mipsPkg::regAddr exp);
    if (got !== exp) begin
        errorCount++;
        $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
        stopOnError();
    end
endtask

task automatic checkBundle(input string name, input mipsPkg::memWbBundle got,
                           input mipsPkg::memWbBundle exp);
    if (got !== exp) begin
        errorCount++;
        $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
        stopOnError();
    end
endtask

// addu rd as it leaves execute
function automatic mipsPkg::exMemBundle aluOp(input mipsPkg::regAddr dest,
                                              input mipsPkg::word val);
    mipsPkg::exMemBundle b;
    b          = '0;
    b.instr    = {6'h00, 10'h000, dest, 11'h021};
    b.pc       = pcNext;
    b.aluOut   = val;
    b.destAddr = dest;
    b.destData = val;
    pcNext     = pcNext + 32'd4;
    return b;
endfunction

function automatic mipsPkg::exMemBundle memOp(input logic [5:0] op,
        input mipsPkg::word addr, input mipsPkg::word data,
        input mipsPkg::regAddr rt, input mipsPkg::regAddr dest);
    mipsPkg::exMemBundle b;
    b           = '0;
    b.instr     = {op, 5'd0, rt, 16'h0000};
    b.pc        = pcNext;
    b.aluOut    = addr;
    b.storeData = data;
    b.rtAddr    = rt;
    b.destAddr  = dest;
    // stale execute result, a load has to replace it
    b.destData  = (dest == '0) ? '0 : 32'hdead_beef;
    pcNext      = pcNext + 32'd4;
    return b;
endfunction

// write-back bundle of a non-memory instruction
function automatic mipsPkg::memWbBundle passBundle(input mipsPkg::exMemBundle b);
    mipsPkg::memWbBundle w;
    w.instr    = b.instr;
    w.pc       = b.pc;
    w.loadData = '0;
    w.destAddr = b.destAddr;
    w.destData = b.destData;
    return w;
endfunction

// drive one instruction, wait for it in write-back, check dest and value
task automatic issue(input mipsPkg::exMemBundle b, input mipsPkg::word expDest);
    int waited;
    exIn = b;
    @(posedge clk);
    #1;
    waited = 1;
    while (wbOut.pc !== b.pc) begin
        if (waited >= wbTimeout) begin
            $display("timeout: instruction at pc %h never reached write-back", b.pc);
            stopOnError();
        end
        @(posedge clk);
        #1;
        waited++;
    end
    // one cycle from issue to write-back
    if (waited != 1) begin
        $display("instruction at pc %h took %0d cycles to write-back", b.pc, waited);
        stopOnError();
    end
    checkAddr("wbOut.destAddr", wbOut.destAddr, b.destAddr);
    checkWord("wbOut.destData", wbOut.destData, expDest);
    if (b.destAddr != '0) begin
        shadow[b.destAddr] = expDest;
    end
endtask

task automatic store(input logic [5:0] op, input mipsPkg::word addr,
                     input mipsPkg::word data, input mipsPkg::regAddr rt);
    issue(memOp(op, addr, data, rt, '0), '0);
    // a store returns no load data
    checkWord("wbOut.loadData", wbOut.loadData, '0);
endtask

task automatic load(input logic [5:0] op, input mipsPkg::word addr,
                    input mipsPkg::regAddr dest, input mipsPkg::word exp);
    issue(memOp(op, addr, '0, dest, dest), exp);
    checkWord("wbOut.loadData", wbOut.loadData, exp);
endtask

// bubble in, one edge for the pending write, then read the debug port
task automatic readBackReg(input mipsPkg::regAddr r);
    exIn    = '0;
    dbgAddr = r;
    @(posedge clk);
    #1;
    checkWord($sformatf("dbgData[r%0d]", r), dbgData, shadow[r]);
endtask

task automatic wordRoundTrip();
    mipsPkg::word    addr;
    mipsPkg::word    data;
    mipsPkg::regAddr dest;
    addr = ($urandom % memWords) << 2;
    data = $urandom;
    dest = mipsPkg::regAddr'($urandom_range(31, 1));
    store(mipsPkg::opSw, addr, data, '0);
    issue(aluOp('0, '0), '0);
    load(mipsPkg::opLw, addr, dest, data);
    readBackReg(dest);
    // one memory size higher aliases the same word
    load(mipsPkg::opLw, addr + memWords * 4, dest, data);
endtask

task automatic byteHalfLanes();
    mipsPkg::word base;
    mipsPkg::word known;
    mipsPkg::word byteVal;
    mipsPkg::word halfVal;
    mipsPkg::word model;
    logic [7:0]   b;
    logic [15:0]  h;
    base    = ($urandom % memWords) << 2;
    known   = $urandom;
    // negative byte into lane 1, positive half into lanes 3:2
    byteVal = $urandom | 32'h0000_0080;
    halfVal = $urandom & 32'hffff_7fff;
    store(mipsPkg::opSw, base, known, '0);
    store(mipsPkg::opSb, base + 1, byteVal, '0);
    store(mipsPkg::opSh, base + 2, halfVal, '0);
    // little-endian lanes, byte 0 in bits 7:0
    model = {halfVal[15:0], byteVal[7:0], known[7:0]};
    for (int off = 0; off < 4; off++) begin
        b = model[off*8 +: 8];
        load(mipsPkg::opLw, base + off, 5'd7, model);
        load(mipsPkg::opLb, base + off, 5'd7, {{24{b[7]}}, b});
        load(mipsPkg::opLbu, base + off, 5'd7, {24'h000000, b});
    end
    for (int off = 0; off < 4; off += 2) begin
        h = model[off*8 +: 16];
        load(mipsPkg::opLh, base + off, 5'd8, {{16{h[15]}}, h});
        load(mipsPkg::opLhu, base + off, 5'd8, {16'h0000, h});
    end
endtask

task automatic storeForwarding();
    mipsPkg::word    addr;
    mipsPkg::word    val;
    mipsPkg::regAddr r;
    addr = ($urandom % memWords) << 2;
    val  = $urandom;
    r    = mipsPkg::regAddr'($urandom_range(31, 1));
    // producer right ahead of the store, store carries the old rt
    issue(aluOp(r, val), val);
    store(mipsPkg::opSw, addr, ~val, r);
    load(mipsPkg::opLw, addr, 5'd3, val);
    // r0 never forwards, so the stale operand lands in memory
    val = $urandom;
    issue(aluOp('0, val), val);
    store(mipsPkg::opSw, addr, ~val, '0);
    load(mipsPkg::opLw, addr, 5'd3, ~val);
endtask

task automatic passThroughRegZero();
    mipsPkg::exMemBundle b;
    mipsPkg::regAddr     r;
    mipsPkg::word        val;
    r   = mipsPkg::regAddr'($urandom_range(31, 1));
    val = $urandom;
    b   = aluOp(r, val);
    issue(b, val);
    checkBundle("wbOut", wbOut, passBundle(b));
    readBackReg(r);
    val = $urandom;
    issue(aluOp('0, val), val);
    readBackReg('0);
endtask

task automatic stallAndClear();
    mipsPkg::exMemBundle x;
    mipsPkg::exMemBundle y;
    mipsPkg::exMemBundle z;
    x = aluOp(5'd10, $urandom);
    y = aluOp(5'd11, $urandom);
    z = aluOp(5'd12, $urandom);
    issue(x, x.destData);
    // y waits on exIn while x stays in write-back
    stall = 1'b1;
    exIn  = y;
    for (int i = 0; i < 3; i++) begin
        @(posedge clk);
        #1;
        checkBundle("wbOut", wbOut, passBundle(x));
    end
    stall = 1'b0;
    issue(y, y.destData);
    // clr wins over stall
    stall = 1'b1;
    clr   = 1'b1;
    exIn  = z;
    @(posedge clk);
    #1;
    checkBundle("wbOut", wbOut, '0);
    stall = 1'b0;
    clr   = 1'b0;
    // z was dropped, r12 keeps its old value
    readBackReg(5'd12);
    readBackReg(5'd11);
    readBackReg(5'd10);
endtask

// File: bench/memWbTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// clock, reset, DUT and the directed test sequence
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module memWbTb;

    // small memory so the address wrap is easy to reach
    localparam int memWords  = 256;
    // edges an instruction may take to reach write-back
    localparam int wbTimeout = 8;

    logic                clk;
    logic                rstN;
    logic                stall;
    logic                clr;
    mipsPkg::exMemBundle exIn;
    mipsPkg::memWbBundle wbOut;
    mipsPkg::regAddr     dbgAddr;
    mipsPkg::word        dbgData;

    // expected register file, updated as results complete
    mipsPkg::word shadow [32];
    // pc of the next instruction, unique per issue
    mipsPkg::word pcNext;
    int           errorCount;

    memWbTop #(
        .memWords (memWords)
    ) u_dut (
        .clk     (clk),
        .rstN    (rstN),
        .stall   (stall),
        .clr     (clr),
        .exIn    (exIn),
        .wbOut   (wbOut),
        .dbgAddr (dbgAddr),
        .dbgData (dbgData)
    );

    `include "memWbTasks.svh"

    // period 4
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        void'($urandom(32'hc095));
        rstN       = 1'b0;
        stall      = 1'b0;
        clr        = 1'b0;
        exIn       = '0;
        dbgAddr    = '0;
        pcNext     = 32'h0000_0400;
        errorCount = 0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        // two cycles of reset, then release just after the edge
        repeat (2) @(posedge clk);
        #1;
        rstN = 1'b1;
        // reset leaves the no-op bundle in write-back
        checkBundle("wbOut", wbOut, '0);

        wordRoundTrip();
        byteHalfLanes();
        storeForwarding();
        passThroughRegZero();
        stallAndClear();

        if (errorCount == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("%0d checks failed", errorCount);
            stopOnError();
        end
    end

endmodule

// File: bench/memWbProperties.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory stage assertions, bound into memStage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module memWbProperties (
    input logic                clk,
    input logic                rstN,
    input logic                stall,
    input logic                clr,
    input logic                isStore,
    input mipsPkg::memWbBundle wbOut
);

    // cleared slot carries no destination
    clearedSlot: assert property (
        @(posedge clk) disable iff (!rstN) clr |=> (wbOut.destAddr == '0)
    ) else $error("wbOut.destAddr nonzero after clr");

    // stall without clr freezes the whole bundle
    holdOnStall: assert property (
        @(posedge clk) disable iff (!rstN) (stall && !clr) |=> $stable(wbOut)
    ) else $error("wbOut changed during stall");

    // a store is never handled as a load in write-back
    storeNotLoad: assert property (
        @(posedge clk) disable iff (!rstN)
            (isStore && !stall && !clr) |=> (wbOut.loadData == '0)
    ) else $error("store carried load data into write-back");

endmodule

bind memStage memWbProperties uProps (
    .clk     (clk),
    .rstN    (rstN),
    .stall   (stall),
    .clr     (clr),
    .isStore (isStore),
    .wbOut   (wbOut)
);

// File: rtl/memWbTop.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memWbTop: memory stage feeding the register file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module memWbTop #(
    parameter int memWords = 1024
) (
    input  logic                clk,
    input  logic                rstN,
    input  logic                stall,
    input  logic                clr,
    // executed instruction from the execute stage
    input  mipsPkg::exMemBundle exIn,
    output mipsPkg::memWbBundle wbOut,
    // debug read port on the register file
    input  mipsPkg::regAddr     dbgAddr,
    output mipsPkg::word        dbgData
);

    memStage #(
        .memWords (memWords)
    ) uMemStage (
        .clk   (clk),
        .rstN  (rstN),
        .stall (stall),
        .clr   (clr),
        .exIn  (exIn),
        .wbOut (wbOut)
    );

    // write-back stage, the register bundle drives the write port
    regFile uRegFile (
        .clk       (clk),
        .rstN      (rstN),
        .writeAddr (wbOut.destAddr),
        .writeData (wbOut.destData),
        .readAddr  (dbgAddr),
        .readData  (dbgData)
    );

endmodule

// File: rtl/regFile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// regFile: 32 x 32 register file, one write port, one debug read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module regFile (
    input  logic             clk,
    input  logic             rstN,
    input  mipsPkg::regAddr  writeAddr,
    input  mipsPkg::word     writeData,
    input  mipsPkg::regAddr  readAddr,
    output mipsPkg::word     readData
);

    mipsPkg::word regs [32];

    // write port, r0 stays zero
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // debug read, combinational
    // value written at an edge shows right after that edge
    assign readData = (readAddr == '0) ? '0 : regs[readAddr];

endmodule

// File: rtl/memStage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// store forwarding, data memory access, write-back select
// and the memory -> write-back pipeline register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module memStage #(
    parameter int memWords = 1024
) (
    input  logic                clk,
    input  logic                rstN,
    input  logic                stall,
    input  logic                clr,
    input  mipsPkg::exMemBundle exIn,
    output mipsPkg::memWbBundle wbOut
);

    // decode results
    logic               isLoad;
    logic               isStore;
    mipsPkg::accessKind kind;

    // store operand after forwarding
    logic               fwdHit;
    mipsPkg::word       storeFwd;

    mipsPkg::word        readData;
    mipsPkg::memWbBundle wbNext;

    instrClassifier uClassifier (
        .instr   (exIn.instr),
        .isLoad  (isLoad),
        .isStore (isStore),
        .kind    (kind)
    );

    // instruction in write-back writes the register the store reads
    // r0 is never forwarded, it always holds zero
    assign fwdHit   = (wbOut.destAddr == exIn.rtAddr) && (wbOut.destAddr != '0);
    assign storeFwd = fwdHit ? wbOut.destData : exIn.storeData;

    dataMemory #(
        .memWords (memWords)
    ) uDataMem (
        .clk       (clk),
        .rstN      (rstN),
        .addr      (exIn.aluOut),
        .writeData (storeFwd),
        .kind      (kind),
        .writeEn   (isStore),
        .readData  (readData)
    );

    // next write-back bundle
    always_comb begin
        wbNext.instr    = exIn.instr;
        wbNext.pc       = exIn.pc;
        // only loads carry load data
        wbNext.loadData = isLoad ? readData : '0;
        wbNext.destAddr = exIn.destAddr;
        // loads write the loaded value, everything else passes through
        wbNext.destData = isLoad ? readData : exIn.destData;
    end

    // pipeline register
    // clr beats stall, zero bundle is a no-op on r0
    always_ff @(posedge clk) begin
        if (!rstN || clr) begin
            wbOut <= '0;
        end else if (!stall) begin
            wbOut <= wbNext;
        end
    end

endmodule

// File: rtl/dataMemory.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dataMemory: word array with byte-lane stores and extending loads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module dataMemory #(
    parameter int memWords = 1024
) (
    input  logic               clk,
    input  logic               rstN,
    input  mipsPkg::word       addr,
    input  mipsPkg::word       writeData,
    input  mipsPkg::accessKind kind,
    input  logic               writeEn,
    output mipsPkg::word       readData
);

    localparam int idxW = $clog2(memWords);

    // storage, little-endian lanes, byte 0 in bits 7:0
    mipsPkg::word mem [memWords];

    logic [idxW-1:0] wordIdx;
    // per-lane write enable and lane-replicated store data
    logic [3:0]      laneEn;
    mipsPkg::word    laneData;
    // addressed word, then the selected half and byte
    mipsPkg::word    rdWord;
    logic [15:0]     rdHalf;
    logic [7:0]      rdByte;

    // word index wraps modulo memWords
    assign wordIdx = idxW'((addr >> 2) % memWords);

    // byte-lane enables from the low address bits
    always_comb begin
        laneEn   = 4'b0000;
        laneData = writeData;
        case (kind)
            mipsPkg::accWord: begin
                laneEn = 4'b1111;
            end
            mipsPkg::accHalf, mipsPkg::accHalfU: begin
                laneEn   = addr[1] ? 4'b1100 : 4'b0011;
                laneData = {2{writeData[15:0]}};
            end
            mipsPkg::accByte, mipsPkg::accByteU: begin
                laneEn   = 4'b0001 << addr[1:0];
                laneData = {4{writeData[7:0]}};
            end
            default: ;
        endcase
    end

    // contents survive reset, stores are just held off while in reset
    always_ff @(posedge clk) begin
        if (rstN && writeEn) begin
            for (int i = 0; i < 4; i++) begin
                if (laneEn[i]) begin
                    mem[wordIdx][i*8 +: 8] <= laneData[i*8 +: 8];
                end
            end
        end
    end

    // combinational read, word reads ignore addr[1:0]
    assign rdWord = mem[wordIdx];
    assign rdHalf = addr[1] ? rdWord[31:16] : rdWord[15:0];

    always_comb begin
        case (addr[1:0])
            2'd0:    rdByte = rdWord[7:0];
            2'd1:    rdByte = rdWord[15:8];
            2'd2:    rdByte = rdWord[23:16];
            default: rdByte = rdWord[31:24];
        endcase
    end

    // extend by kind
    always_comb begin
        case (kind)
            mipsPkg::accWord:  readData = rdWord;
            mipsPkg::accHalf:  readData = {{16{rdHalf[15]}}, rdHalf};
            mipsPkg::accHalfU: readData = {16'h0000, rdHalf};
            mipsPkg::accByte:  readData = {{24{rdByte[7]}}, rdByte};
            mipsPkg::accByteU: readData = {24'h000000, rdByte};
            // no access, nothing to return
            default:           readData = '0;
        endcase
    end

endmodule

// File: rtl/instrClassifier.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instrClassifier: opcode decode into load/store flags and access kind
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module instrClassifier (
    input  mipsPkg::instrWord  instr,
    output logic               isLoad,
    output logic               isStore,
    output mipsPkg::accessKind kind
);

    // primary opcode field
    logic [5:0] opcode;

    assign opcode = instr[31:26];

    always_comb begin
        // anything not listed is a non-memory instruction
        isLoad  = 1'b0;
        isStore = 1'b0;
        kind    = mipsPkg::accNone;
        case (opcode)
            mipsPkg::opLw: begin
                isLoad = 1'b1;
                kind   = mipsPkg::accWord;
            end
            mipsPkg::opLh: begin
                isLoad = 1'b1;
                kind   = mipsPkg::accHalf;
            end
            mipsPkg::opLhu: begin
                isLoad = 1'b1;
                kind   = mipsPkg::accHalfU;
            end
            mipsPkg::opLb: begin
                isLoad = 1'b1;
                kind   = mipsPkg::accByte;
            end
            mipsPkg::opLbu: begin
                isLoad = 1'b1;
                kind   = mipsPkg::accByteU;
            end
            // stores carry no signedness, use the signed codes
            mipsPkg::opSw: begin
                isStore = 1'b1;
                kind    = mipsPkg::accWord;
            end
            mipsPkg::opSh: begin
                isStore = 1'b1;
                kind    = mipsPkg::accHalf;
            end
            mipsPkg::opSb: begin
                isStore = 1'b1;
                kind    = mipsPkg::accByte;
            end
            default: ;
        endcase
    end

endmodule

// File: rtl/mipsPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types, access-kind codes, memory opcodes and the stage
// bundles of the memory / write-back back end
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mipsPkg;

    // data and address values
    typedef logic [31:0] word;
    // register index, 32 registers
    typedef logic [4:0] regAddr;
    // raw instruction
    typedef logic [31:0] instrWord;

    // memory access kind, width plus signedness
    typedef logic [2:0] accessKind;

    localparam accessKind accWord  = 3'd0;
    // signed half
    localparam accessKind accHalf  = 3'd1;
    localparam accessKind accHalfU = 3'd2;
    // signed byte
    localparam accessKind accByte  = 3'd3;
    localparam accessKind accByteU = 3'd4;
    // not a memory access
    localparam accessKind accNone  = 3'd7;

    // primary opcodes, instr[31:26], standard MIPS encodings
    localparam logic [5:0] opLb  = 6'h20;
    localparam logic [5:0] opLh  = 6'h21;
    localparam logic [5:0] opLw  = 6'h23;
    localparam logic [5:0] opLbu = 6'h24;
    localparam logic [5:0] opLhu = 6'h25;
    localparam logic [5:0] opSb  = 6'h28;
    localparam logic [5:0] opSh  = 6'h29;
    localparam logic [5:0] opSw  = 6'h2b;

    // execute -> memory bundle, 170 bits
    typedef struct packed {
        instrWord instr;
        word      pc;
        // effective address for loads and stores
        word      aluOut;
        // rt value as read in decode, may be stale
        word      storeData;
        regAddr   rtAddr;
        regAddr   destAddr;
        // result from execute for non-loads
        word      destData;
    } exMemBundle;

    // memory -> write-back bundle
    // all zero is a no-op, destination 0 writes nothing
    typedef struct packed {
        instrWord instr;
        word      pc;
        // extended load result, zero for non-loads
        word      loadData;
        regAddr   destAddr;
        // value for the register file
        word      destData;
    } memWbBundle;

endpackage
